/* design/apb_pkg.sv */
// Types for the APB peripheral bus
// Used by every bus-facing module and by the testbench for its transfers

package apb_pkg;

    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;

    // Byte address within the peripheral window
    typedef logic [ADDR_W-1:0] apb_addr_t;

    // Read and write data words
    typedef logic [DATA_W-1:0] apb_data_t;

endpackage

/* design/timer_pkg.sv */
// Machine timer constants, value types and register map
// Offsets are byte addresses on the APB window of the timer

package timer_pkg;

    // --------------------------------------------------
    // Sizing
    // --------------------------------------------------
    localparam int N_HARTS = 2;
    localparam int CLK_MHZ = 12;
    localparam int MTIME_W = 64;

    // At least one bit even for a 1 MHz clock
    localparam int TICK_W = (CLK_MHZ > 1) ? $clog2(CLK_MHZ) : 1;

    typedef logic [MTIME_W-1:0] mtime_t;
    typedef logic [TICK_W-1:0]  tick_cnt_t;

    // Compare value that never fires before mtime wraps
    localparam mtime_t MTIMECMP_RESET = '1;

    // --------------------------------------------------
    // Register map
    // --------------------------------------------------
    localparam apb_pkg::apb_addr_t REG_CTRL     = 16'h0000;
    localparam apb_pkg::apb_addr_t REG_MTIME_LO = 16'h0008;
    localparam apb_pkg::apb_addr_t REG_MTIME_HI = 16'h000c;

    // Channel i low word at REG_CMP_BASE + i * CMP_STRIDE, high word 4 above
    localparam apb_pkg::apb_addr_t REG_CMP_BASE = 16'h0010;
    localparam apb_pkg::apb_addr_t CMP_STRIDE   = 16'h0008;

endpackage

/* design/tick_gen.sv */
// Microsecond timebase for the machine timer
// Pulses tick for one clock in every CLK_MHZ clocks

`timescale 1ns/1ps

module tick_gen (
    input  logic clk,
    input  logic rst_n,
    output logic tick
);

    localparam timer_pkg::tick_cnt_t RELOAD =
        timer_pkg::tick_cnt_t'(timer_pkg::CLK_MHZ - 1);

    timer_pkg::tick_cnt_t count;

    // Down-counter, tick registered on the zero cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
            tick  <= 1'b0;
        end else begin
            if (count == '0) begin
                count <= RELOAD;
            end else begin
                count <= count - 1'b1;
            end
            tick <= (count == '0);
        end
    end

endmodule

/* design/timer_apb_front.sv */
// APB front end of the machine timer
// Decodes each access once, owns the control bit and mtime, and hands
// per-channel write strobes and read selects to the compare channels

`timescale 1ns/1ps

module timer_apb_front (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  apb_pkg::apb_addr_t              paddr,
    input  apb_pkg::apb_data_t              pwdata,
    input  logic                            dbg_halt,
    input  logic                            tick,
    output timer_pkg::mtime_t               mtime,
    output logic                            ctrl_en,
    output logic [timer_pkg::N_HARTS-1:0]   cmp_wen_lo,
    output logic [timer_pkg::N_HARTS-1:0]   cmp_wen_hi,
    output logic                            rd_ctrl,
    output logic                            rd_mtime_lo,
    output logic                            rd_mtime_hi,
    output logic [timer_pkg::N_HARTS-1:0]   rd_cmp_lo,
    output logic [timer_pkg::N_HARTS-1:0]   rd_cmp_hi,
    output logic                            pslverr
);

    // --------------------------------------------------
    // Address decode
    // --------------------------------------------------
    logic                          sel_ctrl;
    logic                          sel_mtime_lo;
    logic                          sel_mtime_hi;
    logic [timer_pkg::N_HARTS-1:0] sel_cmp_lo;
    logic [timer_pkg::N_HARTS-1:0] sel_cmp_hi;
    logic                          access;
    logic                          wr_access;
    logic                          mapped;
    logic                          step;

    assign sel_ctrl     = (paddr == timer_pkg::REG_CTRL);
    assign sel_mtime_lo = (paddr == timer_pkg::REG_MTIME_LO);
    assign sel_mtime_hi = (paddr == timer_pkg::REG_MTIME_HI);

    for (genvar i = 0; i < timer_pkg::N_HARTS; i++) begin : g_cmp_decode
        localparam apb_pkg::apb_addr_t LO_ADDR =
            apb_pkg::apb_addr_t'(timer_pkg::REG_CMP_BASE + i * timer_pkg::CMP_STRIDE);
        localparam apb_pkg::apb_addr_t HI_ADDR = LO_ADDR + 16'd4;

        assign sel_cmp_lo[i] = (paddr == LO_ADDR);
        assign sel_cmp_hi[i] = (paddr == HI_ADDR);
    end

    assign mapped = sel_ctrl | sel_mtime_lo | sel_mtime_hi | (|sel_cmp_lo) | (|sel_cmp_hi);

    // Access phase of a transfer, no wait states
    assign access    = psel & penable;
    assign wr_access = access & pwrite;

    assign cmp_wen_lo = sel_cmp_lo & {timer_pkg::N_HARTS{wr_access}};
    assign cmp_wen_hi = sel_cmp_hi & {timer_pkg::N_HARTS{wr_access}};

    assign rd_ctrl     = sel_ctrl & access;
    assign rd_mtime_lo = sel_mtime_lo & access;
    assign rd_mtime_hi = sel_mtime_hi & access;
    assign rd_cmp_lo   = sel_cmp_lo & {timer_pkg::N_HARTS{access}};
    assign rd_cmp_hi   = sel_cmp_hi & {timer_pkg::N_HARTS{access}};

    assign pslverr = access & ~mapped;

    // --------------------------------------------------
    // Control and mtime
    // --------------------------------------------------
    // Halted harts freeze time so the debugger sees a still clock
    assign step = tick & ctrl_en & ~dbg_halt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_en <= 1'b1;
        end else if (sel_ctrl && wr_access) begin
            ctrl_en <= pwdata[0];
        end
    end

    // A bus write wins over the step in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime <= '0;
        end else if (sel_mtime_lo && wr_access) begin
            mtime <= {mtime[63:32], pwdata};
        end else if (sel_mtime_hi && wr_access) begin
            mtime <= {pwdata, mtime[31:0]};
        end else if (step) begin
            mtime <= mtime + 1'b1;
        end
    end

endmodule

/* design/cmp_channel.sv */
// One hart's compare channel of the machine timer
// Holds mtimecmp, written a word at a time from the bus, and raises irq
// while mtime has reached it

`timescale 1ns/1ps

module cmp_channel (
    input  logic               clk,
    input  logic               rst_n,
    input  timer_pkg::mtime_t  mtime,
    input  logic               wen_lo,
    input  logic               wen_hi,
    input  apb_pkg::apb_data_t wdata,
    output timer_pkg::mtime_t  mtimecmp,
    output logic               irq
);

    // Compare value, all ones out of reset so nothing fires early
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtimecmp <= timer_pkg::MTIMECMP_RESET;
        end else begin
            if (wen_lo) begin
                mtimecmp[31:0] <= wdata;
            end
            if (wen_hi) begin
                mtimecmp[63:32] <= wdata;
            end
        end
    end

    // Registered, lags mtime and mtimecmp by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq <= 1'b0;
        end else begin
            irq <= (mtime >= mtimecmp);
        end
    end

endmodule

/* design/timer_readback.sv */
// Read data path of the machine timer
// AND-OR mux of every readable word onto prdata, zero when nothing is
// selected, so an unmapped access reads as zero

`timescale 1ns/1ps

module timer_readback (
    input  logic                          rd_ctrl,
    input  logic                          rd_mtime_lo,
    input  logic                          rd_mtime_hi,
    input  logic [timer_pkg::N_HARTS-1:0] rd_cmp_lo,
    input  logic [timer_pkg::N_HARTS-1:0] rd_cmp_hi,
    input  logic                          ctrl_en,
    input  timer_pkg::mtime_t             mtime,
    input  timer_pkg::mtime_t             mtimecmp [timer_pkg::N_HARTS],
    output apb_pkg::apb_data_t            prdata
);

    localparam int DW = apb_pkg::DATA_W;

    apb_pkg::apb_data_t ctrl_word;

    // Enable in bit 0, rest reads zero
    assign ctrl_word = apb_pkg::apb_data_t'(ctrl_en);

    always_comb begin
        prdata = {DW{rd_ctrl}} & ctrl_word;
        prdata = prdata | ({DW{rd_mtime_lo}} & mtime[31:0]);
        prdata = prdata | ({DW{rd_mtime_hi}} & mtime[63:32]);

        // Selects are one-hot, so OR-ing the channels is safe
        for (int i = 0; i < timer_pkg::N_HARTS; i++) begin
            prdata = prdata | ({DW{rd_cmp_lo[i]}} & mtimecmp[i][31:0]);
            prdata = prdata | ({DW{rd_cmp_hi[i]}} & mtimecmp[i][63:32]);
        end
    end

endmodule

/* design/timer_subsystem.sv */
// Machine timer subsystem on the APB peripheral bus
// Microsecond timebase, shared mtime and one compare channel per hart

`timescale 1ns/1ps

module timer_subsystem (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  apb_pkg::apb_addr_t            paddr,
    input  apb_pkg::apb_data_t            pwdata,
    output apb_pkg::apb_data_t            prdata,
    output logic                          pslverr,
    input  logic                          dbg_halt,
    output logic [timer_pkg::N_HARTS-1:0] irq
);

    logic                          tick;
    timer_pkg::mtime_t             mtime;
    logic                          ctrl_en;
    logic [timer_pkg::N_HARTS-1:0] cmp_wen_lo;
    logic [timer_pkg::N_HARTS-1:0] cmp_wen_hi;
    logic                          rd_ctrl;
    logic                          rd_mtime_lo;
    logic                          rd_mtime_hi;
    logic [timer_pkg::N_HARTS-1:0] rd_cmp_lo;
    logic [timer_pkg::N_HARTS-1:0] rd_cmp_hi;
    timer_pkg::mtime_t             mtimecmp [timer_pkg::N_HARTS];

    tick_gen u_tick_gen (
        .clk  (clk),
        .rst_n(rst_n),
        .tick (tick)
    );

    timer_apb_front u_front (
        .clk        (clk),
        .rst_n      (rst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .dbg_halt   (dbg_halt),
        .tick       (tick),
        .mtime      (mtime),
        .ctrl_en    (ctrl_en),
        .cmp_wen_lo (cmp_wen_lo),
        .cmp_wen_hi (cmp_wen_hi),
        .rd_ctrl    (rd_ctrl),
        .rd_mtime_lo(rd_mtime_lo),
        .rd_mtime_hi(rd_mtime_hi),
        .rd_cmp_lo  (rd_cmp_lo),
        .rd_cmp_hi  (rd_cmp_hi),
        .pslverr    (pslverr)
    );

    // --------------------------------------------------
    // One compare channel per hart
    // --------------------------------------------------
    for (genvar i = 0; i < timer_pkg::N_HARTS; i++) begin : g_chan
        cmp_channel u_chan (
            .clk     (clk),
            .rst_n   (rst_n),
            .mtime   (mtime),
            .wen_lo  (cmp_wen_lo[i]),
            .wen_hi  (cmp_wen_hi[i]),
            .wdata   (pwdata),
            .mtimecmp(mtimecmp[i]),
            .irq     (irq[i])
        );
    end

    timer_readback u_readback (
        .rd_ctrl    (rd_ctrl),
        .rd_mtime_lo(rd_mtime_lo),
        .rd_mtime_hi(rd_mtime_hi),
        .rd_cmp_lo  (rd_cmp_lo),
        .rd_cmp_hi  (rd_cmp_hi),
        .ctrl_en    (ctrl_en),
        .mtime      (mtime),
        .mtimecmp   (mtimecmp),
        .prdata     (prdata)
    );

endmodule

/* testbench/timer_subsystem_assert.sv */
// Concurrent checks on the ports of the timer subsystem
// Bound into every timer_subsystem instance at the end of this file

`timescale 1ns/1ps

module timer_subsystem_assert (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          psel,
    input logic                          penable,
    input apb_pkg::apb_data_t            prdata,
    input logic                          pslverr,
    input logic [timer_pkg::N_HARTS-1:0] irq
);

    // --------------------------------------------------
    // Reset behavior
    // --------------------------------------------------
    irq_low_in_reset: assert property (@(posedge clk) !rst_n |-> (irq == '0 && !pslverr))
        else $error("irq or pslverr high during reset");

    // First cycle out of reset still has every irq low
    irq_low_after_reset: assert property (@(posedge clk) $rose(rst_n) |=> (irq == '0))
        else $error("irq high in the first cycle after reset");

    // --------------------------------------------------
    // APB error response
    // --------------------------------------------------
    slverr_in_access: assert property (
        @(posedge clk) disable iff (!rst_n) pslverr |-> (psel && penable))
        else $error("pslverr high outside an access cycle");

    slverr_zero_data: assert property (
        @(posedge clk) disable iff (!rst_n) pslverr |-> (prdata == '0))
        else $error("prdata not zero while pslverr is high");

endmodule

bind timer_subsystem timer_subsystem_assert u_assert (
    .clk    (clk),
    .rst_n  (rst_n),
    .psel   (psel),
    .penable(penable),
    .prdata (prdata),
    .pslverr(pslverr),
    .irq    (irq)
);

/* testbench/tb_timer_subsystem.sv */
// Testbench for the machine timer subsystem
// Drives APB transfers on the falling clock edge and checks reset values,
// register read-back, counting, debug halt, per-hart irq and unmapped access

`timescale 1ns/1ps

module tb_timer_subsystem;

    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 4;
    localparam int TEST_CYCLES  = 2500;
    // Double the expected test length plus some slack
    localparam int MAX_CYCLES   = 2 * TEST_CYCLES + 1000;
    localparam int COUNT_TICKS  = 100;
    localparam int HALT_WAIT    = 50;
    localparam int NH           = timer_pkg::N_HARTS;
    localparam int SEED         = 65198;

    logic                clk;
    logic                rst_n;
    logic                psel;
    logic                penable;
    logic                pwrite;
    apb_pkg::apb_addr_t  paddr;
    apb_pkg::apb_data_t  pwdata;
    apb_pkg::apb_data_t  prdata;
    logic                pslverr;
    logic                dbg_halt;
    logic [NH-1:0]       irq;

    // Expected register contents
    logic                exp_ctrl;
    timer_pkg::mtime_t   exp_mtime;
    timer_pkg::mtime_t   exp_cmp [NH];
    int                  cycles;

    timer_subsystem uut (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pslverr (pslverr),
        .dbg_halt(dbg_halt),
        .irq     (irq)
    );

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Watchdog on the whole run
    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run did not finish within %0d cycles", MAX_CYCLES);
        $display("SIMULATION FAILED");
        $fatal(1, "timeout");
    end

    // --------------------------------------------------
    // Bus and check helpers
    // --------------------------------------------------
    function automatic apb_pkg::apb_addr_t cmp_addr(input int idx, input bit hi);
        return timer_pkg::REG_CMP_BASE + apb_pkg::apb_addr_t'(idx) * timer_pkg::CMP_STRIDE
               + (hi ? 16'd4 : 16'd0);
    endfunction

    task automatic check_word(input string name, input apb_pkg::apb_data_t expected,
                              input apb_pkg::apb_data_t actual);
        assert (actual === expected) else begin
            $display("Error %s: expected %h actual %h", name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic apb_write(input apb_pkg::apb_addr_t addr, input apb_pkg::apb_data_t data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // Samples in the middle of the low half of the access cycle
    task automatic apb_read(input apb_pkg::apb_addr_t addr, output apb_pkg::apb_data_t data,
                            output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        #(HALF_PERIOD / 2);
        data = prdata;
        err  = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_check(input string name, input apb_pkg::apb_addr_t addr,
                              input apb_pkg::apb_data_t expected);
        apb_pkg::apb_data_t data;
        logic               err;
        apb_read(addr, data, err);
        check_word(name, expected, data);
        check_word({name, " pslverr"}, '0, apb_pkg::apb_data_t'(err));
    endtask

    task automatic write_mtime(input timer_pkg::mtime_t value);
        apb_write(timer_pkg::REG_MTIME_LO, value[31:0]);
        apb_write(timer_pkg::REG_MTIME_HI, value[63:32]);
        exp_mtime = value;
    endtask

    task automatic write_cmp(input int idx, input timer_pkg::mtime_t value);
        apb_write(cmp_addr(idx, 1'b0), value[31:0]);
        apb_write(cmp_addr(idx, 1'b1), value[63:32]);
        exp_cmp[idx] = value;
    endtask

    task automatic check_regs(input string name);
        read_check({name, " ctrl"}, timer_pkg::REG_CTRL, apb_pkg::apb_data_t'(exp_ctrl));
        read_check({name, " mtime lo"}, timer_pkg::REG_MTIME_LO, exp_mtime[31:0]);
        read_check({name, " mtime hi"}, timer_pkg::REG_MTIME_HI, exp_mtime[63:32]);
        for (int i = 0; i < NH; i++) begin
            read_check($sformatf("%s cmp%0d lo", name, i), cmp_addr(i, 1'b0), exp_cmp[i][31:0]);
            read_check($sformatf("%s cmp%0d hi", name, i), cmp_addr(i, 1'b1), exp_cmp[i][63:32]);
        end
    endtask

    // irq is registered, so allow two cycles after the write
    task automatic check_irq(input string name, input logic [NH-1:0] expected);
        repeat (2) @(negedge clk);
        check_word(name, apb_pkg::apb_data_t'(expected), apb_pkg::apb_data_t'(irq));
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        apb_pkg::apb_data_t t0;
        apb_pkg::apb_data_t t1;
        apb_pkg::apb_data_t diff;
        logic               err;
        timer_pkg::mtime_t  v;

        void'($urandom(SEED));
        rst_n    = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        dbg_halt = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        // Reset values
        read_check("reset ctrl", timer_pkg::REG_CTRL, 32'd1);
        for (int i = 0; i < NH; i++) begin
            read_check($sformatf("reset cmp%0d lo", i), cmp_addr(i, 1'b0), '1);
            read_check($sformatf("reset cmp%0d hi", i), cmp_addr(i, 1'b1), '1);
        end
        check_word("reset irq", '0, apb_pkg::apb_data_t'(irq));

        // Read-back with counting off
        apb_write(timer_pkg::REG_CTRL, 32'd0);
        exp_ctrl = 1'b0;
        write_mtime({$urandom, $urandom});
        for (int i = 0; i < NH; i++) begin
            write_cmp(i, {$urandom, $urandom});
        end
        check_regs("readback");
        repeat (HALT_WAIT) @(negedge clk);
        check_regs("readback held");

        // Counting at one step per microsecond
        apb_write(timer_pkg::REG_CTRL, 32'd1);
        exp_ctrl = 1'b1;
        apb_read(timer_pkg::REG_MTIME_LO, t0, err);
        repeat (COUNT_TICKS * timer_pkg::CLK_MHZ) @(negedge clk);
        apb_read(timer_pkg::REG_MTIME_LO, t1, err);
        diff = t1 - t0;
        assert (diff >= COUNT_TICKS - 1 && diff <= COUNT_TICKS + 1) else begin
            $display("Error count: expected %0d to %0d actual %0d",
                     COUNT_TICKS - 1, COUNT_TICKS + 1, diff);
            $display("SIMULATION FAILED");
            $fatal(1, "count out of range");
        end

        // Debug halt freezes mtime
        dbg_halt = 1'b1;
        apb_read(timer_pkg::REG_MTIME_LO, t0, err);
        repeat (HALT_WAIT) @(negedge clk);
        apb_read(timer_pkg::REG_MTIME_LO, t1, err);
        check_word("debug halt", t0, t1);
        dbg_halt = 1'b0;

        // Per-channel interrupts at a frozen mtime
        apb_write(timer_pkg::REG_CTRL, 32'd0);
        exp_ctrl = 1'b0;
        v = {$urandom & 32'h7fff_ffff, $urandom};
        write_mtime(v);
        for (int i = 0; i < NH; i++) begin
            write_cmp(i, v + 64'd1);
        end
        check_irq("irq all clear", '0);
        for (int i = 0; i < NH; i++) begin
            write_cmp(i, v);
            check_irq($sformatf("irq%0d set", i), NH'(1) << i);
            write_cmp(i, v + 64'd1);
            check_irq($sformatf("irq%0d clear", i), '0);
        end

        // Unmapped addresses
        apb_read(16'h0004, t0, err);
        check_word("unmapped 0x04 pslverr", 32'd1, apb_pkg::apb_data_t'(err));
        check_word("unmapped 0x04 prdata", '0, t0);
        apb_read(cmp_addr(NH, 1'b0), t0, err);
        check_word("unmapped past cmp pslverr", 32'd1, apb_pkg::apb_data_t'(err));
        check_word("unmapped past cmp prdata", '0, t0);
        apb_write(16'h0004, $urandom);
        apb_write(cmp_addr(NH, 1'b0), $urandom);
        check_regs("unmapped write");

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* sim.f */
design/apb_pkg.sv
design/timer_pkg.sv
design/tick_gen.sv
design/timer_apb_front.sv
design/cmp_channel.sv
design/timer_readback.sv
design/timer_subsystem.sv
testbench/timer_subsystem_assert.sv
testbench/tb_timer_subsystem.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := tb_timer_subsystem
FILELIST  := sim.f
OBJ_DIR   := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Exit status of the simulation binary is the pass or fail result
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
